/* hw/audio_pkg.sv */
`default_nettype none

package audio_pkg;

    // --------------------
    // Microphone samples
    // --------------------

    // INMP441 word length in the left slot.
    localparam int mic_w = 24;

    // Signed two's complement sample, MSB first on the wire.
    typedef logic signed [mic_w-1:0] mic_sample_t;

    // --------------------
    // Levels
    // --------------------

    // Highest set bit of the magnitude plus one.
    // Zero for a silent sample, mic_w at full scale.
    localparam int level_w = $clog2(mic_w + 1);

    typedef logic [level_w-1:0] mic_level_t;

endpackage

`default_nettype wire

/* hw/board_pkg.sv */
`default_nettype none

package board_pkg;

    // --------------------
    // Seven-segment module
    // --------------------

    // Eight digits share one set of segment lines.
    localparam int n_digits = 8;

    // Segment lines a to g and then dp, from bit 7 down.
    // A high bit lights the segment.
    typedef logic [7:0] seg_t;

    // One hex nibble per digit.
    typedef logic [3:0] hex_digit_t;

    // One-hot digit select, high selects.
    typedef logic [n_digits-1:0] digit_sel_t;

endpackage

`default_nettype wire

/* hw/slow_clk_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module slow_clk_gen
#(
    parameter int clk_mhz     = 100,
    parameter int slow_clk_hz = 1
)
(
    input  wire  clk,
    input  wire  arst_n,
    output logic slow_clk
);

    // Clocks per half period of the slow clock.
    localparam int half_period = clk_mhz * 1_000_000 / (2 * slow_clk_hz);
    localparam int cnt_w       = half_period > 1 ? $clog2(half_period) : 1;

    logic [cnt_w-1:0] cnt;

    // Count down, reload and flip the output at zero.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cnt      <= cnt_w'(half_period - 1);
            slow_clk <= 1'b0;
        end else if (cnt == '0) begin
            cnt      <= cnt_w'(half_period - 1);
            slow_clk <= ~slow_clk;
        end else begin
            cnt      <= cnt - 1'b1;
        end
    end

endmodule

`default_nettype wire

/* hw/inmp441_mic_i2s_receiver.sv */
`timescale 1ns/1ps
`default_nettype none

module inmp441_mic_i2s_receiver
    import audio_pkg::*;
#(
    parameter int clk_mhz = 100
)
(
    input  wire         clk,
    input  wire         arst_n,
    output logic        lr,
    output logic        ws,
    output logic        sck,
    input  wire         sd,
    output mic_sample_t value
);

    // --------------------
    // Clock limit
    // --------------------

    // sck is clk / 8, the microphone is rated for 3.2 MHz at most.
    if (clk_mhz * 1000 / 8 >= 3200) begin : g_sck_limit
        $warning("sck of %0d kHz is above the INMP441 limit", clk_mhz * 1000 / 8);
    end

    // --------------------
    // sck and ws
    // --------------------

    logic [1:0] presc;
    logic [5:0] bit_cnt;
    logic       sck_rise;
    logic       sck_fall;

    // Edges seen one clock ahead, at the clock where sck flips.
    assign sck_rise = (presc == 2'd3) && !sck;
    assign sck_fall = (presc == 2'd3) &&  sck;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            presc   <= '0;
            sck     <= 1'b0;
            bit_cnt <= '0;
        end else begin
            presc <= presc + 2'd1;

            if (presc == 2'd3)
                sck <= ~sck;

            // 32 sck periods per slot, 64 per frame.
            if (sck_fall)
                bit_cnt <= bit_cnt + 6'd1;
        end
    end

    // Upper half of the frame is the right slot.
    assign ws = bit_cnt[5];

    // Left channel select on the microphone.
    assign lr = 1'b0;

    // --------------------
    // Sample capture
    // --------------------

    logic        capture;
    logic        load;
    mic_sample_t shreg;

    // One-bit I2S delay, MSB on the second rising edge of the slot.
    assign capture = (bit_cnt >= 6'd1) && (bit_cnt <= 6'(mic_w));

    always_ff @(posedge clk) begin
        if (sck_rise && capture)
            shreg <= {shreg[mic_w-2:0], sd};
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n)
            load <= 1'b0;
        else
            load <= sck_rise && (bit_cnt == 6'(mic_w));
    end

    // Holds the last full left word until the next frame.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n)
            value <= '0;
        else if (load)
            value <= shreg;
    end

endmodule

`default_nettype wire

/* hw/seven_segment_display.sv */
`timescale 1ns/1ps
`default_nettype none

module seven_segment_display
    import board_pkg::*;
#(
    parameter int clk_mhz = 100
)
(
    input  wire                          clk,
    input  wire                          arst_n,
    input  hex_digit_t [n_digits-1:0]    digits,
    output seg_t                         abcdefgh,
    output digit_sel_t                   digit
);

    // 256 clocks per digit.
    localparam int scan_w  = 8;
    localparam int sel_w   = $clog2(n_digits);
    localparam int scan_hz = clk_mhz * 1_000_000 / (2 ** (scan_w + sel_w));

    if (scan_hz < 200) begin : g_flicker
        $warning("Display refresh of %0d Hz may flicker", scan_hz);
    end

    // --------------------
    // Refresh
    // --------------------

    logic [scan_w+sel_w-1:0] refresh;
    logic [sel_w-1:0]        idx;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n)
            refresh <= '0;
        else
            refresh <= refresh + 1'b1;
    end

    // Upper bits walk digits 0 to 7.
    assign idx   = refresh[scan_w +: sel_w];
    assign digit = digit_sel_t'(1) << idx;

    // --------------------
    // Decoder
    // --------------------

    function automatic seg_t hex_to_seg(input hex_digit_t h);
        case (h)
            4'h0:    hex_to_seg = 8'b1111_1100;
            4'h1:    hex_to_seg = 8'b0110_0000;
            4'h2:    hex_to_seg = 8'b1101_1010;
            4'h3:    hex_to_seg = 8'b1111_0010;
            4'h4:    hex_to_seg = 8'b0110_0110;
            4'h5:    hex_to_seg = 8'b1011_0110;
            4'h6:    hex_to_seg = 8'b1011_1110;
            4'h7:    hex_to_seg = 8'b1110_0000;
            4'h8:    hex_to_seg = 8'b1111_1110;
            4'h9:    hex_to_seg = 8'b1111_0110;
            4'ha:    hex_to_seg = 8'b1110_1110;
            4'hb:    hex_to_seg = 8'b0011_1110;
            4'hc:    hex_to_seg = 8'b1001_1100;
            4'hd:    hex_to_seg = 8'b0111_1010;
            4'he:    hex_to_seg = 8'b1001_1110;
            default: hex_to_seg = 8'b1000_1110;
        endcase
    endfunction

    // Decimal point stays dark, bit 0 of every pattern.
    assign abcdefgh = hex_to_seg(digits[idx]);

endmodule

`default_nettype wire

/* hw/lab_top.sv */
`timescale 1ns/1ps
`default_nettype none

module lab_top
    import board_pkg::*, audio_pkg::*;
#(
    parameter int clk_mhz = 100,
    parameter int w_key   = 5,
    parameter int w_sw    = 16,
    parameter int w_led   = 16
)
(
    input  wire               clk,
    input  wire               slow_clk,
    input  wire               arst_n,
    input  wire  [w_key-1:0]  key,
    input  wire  [w_sw-1:0]   sw,
    output logic [w_led-1:0]  led,
    output seg_t              abcdefgh,
    output digit_sel_t        digit,
    input  mic_sample_t       mic
);

    // --------------------
    // Magnitude and level
    // --------------------

    logic [mic_w-1:0] mag;
    mic_level_t       level;

    // Unsigned magnitude, so -2^23 maps to 2^23 and reaches full level.
    assign mag = mic[mic_w-1] ? (~mic + 1'b1) : mic;

    // Priority search, the highest set bit wins.
    always_comb begin
        level = '0;
        for (int i = 0; i < mic_w; i++) begin
            if (mag[i])
                level = mic_level_t'(i + 1);
        end
    end

    // --------------------
    // LED bar
    // --------------------

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            led <= '0;
        end else begin
            for (int i = 0; i < w_led; i++)
                led[i] <= (int'(level) > i + 8);
        end
    end

    // --------------------
    // Freeze and peak hold
    // --------------------

    mic_sample_t shown;
    mic_level_t  peak;
    logic [2:0]  slow_sync;
    logic        tick;

    // Two flops into clk, the third finds the rising edge.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n)
            slow_sync <= '0;
        else
            slow_sync <= {slow_sync[1:0], slow_clk};
    end

    assign tick = slow_sync[1] & ~slow_sync[2];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            shown <= '0;
            peak  <= '0;
        end else begin
            if (!sw[0])
                shown <= mic;

            // key[1] is btnc.
            if (key[1] || tick)
                peak <= level;
            else if (level > peak)
                peak <= level;
        end
    end

    // --------------------
    // Display
    // --------------------

    // Digits 7 and 6 hold the peak, 5 to 0 the sample.
    hex_digit_t [n_digits-1:0] digits;

    assign digits = {3'b000, peak, shown};

    seven_segment_display
    #(
        .clk_mhz  ( clk_mhz  )
    )
    i_display
    (
        .clk      ( clk      ),
        .arst_n   ( arst_n   ),
        .digits   ( digits   ),
        .abcdefgh ( abcdefgh ),
        .digit    ( digit    )
    );

endmodule

`default_nettype wire

/* hw/board_specific_top.sv */
`timescale 1ns/1ps
`default_nettype none

module board_specific_top
    import board_pkg::*, audio_pkg::*;
#(
    parameter int clk_mhz     = 100,
    parameter int slow_clk_hz = 1,
    parameter int w_key       = 5,
    parameter int w_sw        = 16,
    parameter int w_led       = 16
)
(
    input  wire              clk100mhz,
    input  wire              arst_n,

    input  wire              btnc,
    input  wire              btnu,
    input  wire              btnl,
    input  wire              btnr,
    input  wire              btnd,

    input  wire  [w_sw-1:0]  sw,
    output logic [w_led-1:0] led,

    output logic             ca,
    output logic             cb,
    output logic             cc,
    output logic             cd,
    output logic             ce,
    output logic             cf,
    output logic             cg,
    output logic             dp,

    output digit_sel_t       an,

    output logic             jd_lr,
    output logic             jd_ws,
    output logic             jd_sck,
    input  wire              jd_sd,
    output logic             jd_gnd,
    output logic             jd_vcc
);

    wire clk = clk100mhz;

    // --------------------
    // Display polarity
    // --------------------

    seg_t       abcdefgh;
    digit_sel_t digit;

    // Segments and anodes are active low on the board.
    assign {ca, cb, cc, cd, ce, cf, cg, dp} = ~abcdefgh;
    assign an = ~digit;

    // --------------------
    // Slow clock
    // --------------------

    logic slow_clk;

    slow_clk_gen
    #(
        .clk_mhz     ( clk_mhz     ),
        .slow_clk_hz ( slow_clk_hz )
    )
    i_slow_clk_gen
    (
        .clk         ( clk         ),
        .arst_n      ( arst_n      ),
        .slow_clk    ( slow_clk    )
    );

    // --------------------
    // Level meter
    // --------------------

    mic_sample_t mic;

    lab_top
    #(
        .clk_mhz  ( clk_mhz  ),
        .w_key    ( w_key    ),
        .w_sw     ( w_sw     ),
        .w_led    ( w_led    )
    )
    i_top
    (
        .clk      ( clk      ),
        .slow_clk ( slow_clk ),
        .arst_n   ( arst_n   ),
        .key      ( {btnd, btnu, btnl, btnc, btnr} ),
        .sw       ( sw       ),
        .led      ( led      ),
        .abcdefgh ( abcdefgh ),
        .digit    ( digit    ),
        .mic      ( mic      )
    );

    // --------------------
    // Microphone on jd
    // --------------------

    inmp441_mic_i2s_receiver
    #(
        .clk_mhz ( clk_mhz )
    )
    i_microphone
    (
        .clk     ( clk     ),
        .arst_n  ( arst_n  ),
        .lr      ( jd_lr   ),
        .ws      ( jd_ws   ),
        .sck     ( jd_sck  ),
        .sd      ( jd_sd   ),
        .value   ( mic     )
    );

    // Power for the microphone module.
    assign jd_gnd = 1'b0;
    assign jd_vcc = 1'b1;

endmodule

`default_nettype wire

/* verification/inmp441_mic_model.sv */
`timescale 1ns/1ps
`default_nettype none

module inmp441_mic_model
    import audio_pkg::*;
(
    input  wire         sck,
    input  wire         ws,
    input  wire         lr,
    input  mic_sample_t left,
    input  mic_sample_t right,
    output logic        sd
);

    // --------------------
    // Slot tracking
    // --------------------

    mic_sample_t word;
    int          pos;
    logic        ws_q;

    initial begin
        sd   = 1'b0;
        word = '0;
        pos  = mic_w;
        ws_q = 1'b1;
    end

    // Data changes on falling sck, the receiver samples on the rising edge.
    // The short delay lets ws settle after the edge that moved it.
    always @(negedge sck) begin
        #1;
        if (ws !== ws_q) begin
            // New slot, the word is latched here and held for the whole slot.
            word = (ws == lr) ? left : right;
            pos  = 0;
            sd   = 1'b0;
        end else if (pos < mic_w) begin
            // One bit of I2S delay, then MSB first.
            sd  = word[mic_w-1-pos];
            pos = pos + 1;
        end else begin
            sd = 1'b0;
        end
        ws_q = ws;
    end

endmodule

`default_nettype wire

/* verification/tb_board_specific_top.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_board_specific_top
    import board_pkg::*, audio_pkg::*;
();

    localparam int clk_mhz     = 25;
    localparam int slow_clk_hz = 500;
    localparam int slow_period = clk_mhz * 1_000_000 / slow_clk_hz;
    localparam int frame_clks  = 512;
    localparam int scan_clks   = 2048;
    localparam int hold_clks   = 51_000;
    localparam int tick_margin = 8000;

    // Standard hex font, a to g then dp.
    localparam seg_t hex_font [16] = '{
        8'hfc, 8'h60, 8'hda, 8'hf2, 8'h66, 8'hb6, 8'hbe, 8'he0,
        8'hfe, 8'hf6, 8'hee, 8'h3e, 8'h9c, 8'h7a, 8'h9e, 8'h8e
    };

    typedef struct {
        mic_sample_t left;
        mic_sample_t right;
        logic        sw0;
        logic        btnc;
        logic        hold;
        mic_sample_t exp_sample;
        logic [15:0] exp_led;
        mic_level_t  exp_peak;
    } row_t;

    logic        clk;
    logic        arst_n;
    logic        btnc;
    logic        btnu;
    logic        btnl;
    logic        btnr;
    logic        btnd;
    logic [15:0] sw;
    logic [15:0] led;
    logic        ca;
    logic        cb;
    logic        cc;
    logic        cd;
    logic        ce;
    logic        cf;
    logic        cg;
    logic        dp;
    digit_sel_t  an;
    logic        jd_lr;
    logic        jd_ws;
    logic        jd_sck;
    logic        jd_sd;
    logic        jd_gnd;
    logic        jd_vcc;
    mic_sample_t left;
    mic_sample_t right;

    row_t        rows[$];
    row_t        cur;
    logic [31:0] lcg_state;
    mic_sample_t model_shown;
    mic_level_t  model_peak;
    mic_level_t  model_level;
    int          next_tick;
    int          cycle_cnt = 0;

    board_specific_top
    #(
        .clk_mhz     ( clk_mhz     ),
        .slow_clk_hz ( slow_clk_hz )
    )
    dut
    (
        .clk100mhz ( clk    ), .arst_n ( arst_n ),
        .btnc ( btnc ), .btnu ( btnu ), .btnl ( btnl ), .btnr ( btnr ), .btnd ( btnd ),
        .sw   ( sw   ), .led  ( led  ),
        .ca   ( ca   ), .cb   ( cb   ), .cc   ( cc   ), .cd   ( cd   ),
        .ce   ( ce   ), .cf   ( cf   ), .cg   ( cg   ), .dp   ( dp   ),
        .an   ( an   ),
        .jd_lr  ( jd_lr  ), .jd_ws  ( jd_ws  ), .jd_sck ( jd_sck ),
        .jd_sd  ( jd_sd  ), .jd_gnd ( jd_gnd ), .jd_vcc ( jd_vcc )
    );

    inmp441_mic_model i_mic
    (
        .sck   ( jd_sck ),
        .ws    ( jd_ws  ),
        .lr    ( jd_lr  ),
        .left  ( left   ),
        .right ( right  ),
        .sd    ( jd_sd  )
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Clocks since reset release, used to place the slow ticks.
    always @(posedge clk) begin
        if (arst_n)
            cycle_cnt <= cycle_cnt + 1;
    end

    // --------------------
    // Reference rules
    // --------------------

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic mic_level_t level_of(input mic_sample_t s);
        longint     mag;
        mic_level_t lvl;
        mag = s;
        if (mag < 0)
            mag = -mag;
        lvl = '0;
        while (mag != 0) begin
            lvl = lvl + 1'b1;
            mag = mag >> 1;
        end
        return lvl;
    endfunction

    // Thermometer bar, one LED per level above 8.
    function automatic logic [15:0] led_of(input mic_level_t lvl);
        int          n;
        logic [16:0] one;
        n   = (lvl > 8) ? int'(lvl) - 8 : 0;
        one = 17'd1 << n;
        return 16'(one - 17'd1);
    endfunction

    function automatic row_t predict(input row_t r);
        mic_level_t lvl;
        lvl = level_of(r.left);
        if (!r.sw0)
            model_shown = r.left;
        if (lvl > model_peak)
            model_peak = lvl;
        // A btnc press or a slow tick during the hold clears to the current level.
        if (r.btnc || r.hold)
            model_peak = lvl;
        model_level  = lvl;
        r.exp_sample = model_shown;
        r.exp_led    = led_of(lvl);
        r.exp_peak   = model_peak;
        return r;
    endfunction

    task automatic add_row(input mic_sample_t l, input logic s, input logic b, input logic h);
        row_t r;
        lcg_state    = lcg_next(lcg_state);
        r.left       = l;
        r.right      = lcg_state[31:8];
        r.sw0        = s;
        r.btnc       = b;
        r.hold       = h;
        r.exp_sample = '0;
        r.exp_led    = '0;
        r.exp_peak   = '0;
        rows.push_back(r);
    endtask

    task automatic build_table();
        // Hex readout and bar.
        add_row(24'h123456, 1'b0, 1'b0, 1'b0);
        add_row(24'hfedcba, 1'b0, 1'b0, 1'b0);
        add_row(24'h000000, 1'b0, 1'b0, 1'b0);
        add_row(24'h7fffff, 1'b0, 1'b0, 1'b0);
        add_row(24'h800000, 1'b0, 1'b0, 1'b0);
        add_row(24'h000080, 1'b0, 1'b0, 1'b0);
        add_row(24'h000100, 1'b0, 1'b0, 1'b0);
        // Freeze.
        add_row(24'h0abcde, 1'b1, 1'b0, 1'b0);
        add_row(24'hf00000, 1'b1, 1'b0, 1'b0);
        add_row(24'h00ffff, 1'b0, 1'b0, 1'b0);
        // Peak over a rising then falling run.
        add_row(24'h000010, 1'b0, 1'b1, 1'b0);
        add_row(24'h000400, 1'b0, 1'b0, 1'b0);
        add_row(24'h040000, 1'b0, 1'b0, 1'b0);
        add_row(24'h001000, 1'b0, 1'b0, 1'b0);
        add_row(24'h000003, 1'b0, 1'b0, 1'b0);
        add_row(24'h000020, 1'b0, 1'b1, 1'b0);
        // Long hold across one slow period, below the held peak.
        add_row(24'h000007, 1'b0, 1'b0, 1'b1);
        add_row(24'hffffff, 1'b0, 1'b0, 1'b0);
    endtask

    // --------------------
    // Checks
    // --------------------

    task automatic abort_run();
        $display("Done: errors found");
        $fatal(1, "Simulation stopped at the first failure");
    endtask

    task automatic check_sample(input string name, input mic_sample_t got,
                                input mic_sample_t exp);
        if (got !== exp) begin
            $display("ERROR %s: got %h, expected %h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_led(input string name, input logic [15:0] got, input logic [15:0] exp);
        if (got !== exp) begin
            $display("ERROR %s: got %h, expected %h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_level(input string name, input mic_level_t got, input mic_level_t exp);
        if (got !== exp) begin
            $display("ERROR %s: got %h, expected %h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_pin(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("ERROR %s: got %h, expected %h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic wait_ws_fall();
        int   n;
        logic prev;
        logic seen;
        n    = 0;
        seen = 1'b0;
        while (!seen && n < 2 * frame_clks) begin
            prev = jd_ws;
            @(negedge clk);
            seen = prev && !jd_ws;
            n++;
        end
        if (!seen) begin
            $display("Timeout: no ws falling edge within %0d clocks", 2 * frame_clks);
            abort_run();
        end
    endtask

    // Waits for the digit's anode and decodes the active-low segment lines.
    task automatic read_digit(input int i, output hex_digit_t h);
        int   n;
        seg_t pat;
        logic found;
        n = 0;
        while (an[i] !== 1'b0 && n < 2 * scan_clks) begin
            @(negedge clk);
            n++;
        end
        if (an[i] !== 1'b0) begin
            $display("Timeout: digit %0d was never selected", i);
            abort_run();
        end
        pat   = ~{ca, cb, cc, cd, ce, cf, cg, dp};
        found = 1'b0;
        h     = '0;
        for (int d = 0; d < 16; d++) begin
            if (hex_font[d] == pat) begin
                h     = hex_digit_t'(d);
                found = 1'b1;
            end
        end
        if (!found) begin
            $display("Digit %0d shows segment pattern %h, which is no hex digit", i, pat);
            abort_run();
        end
    endtask

    task automatic check_display(input mic_sample_t exp_sample, input mic_level_t exp_peak);
        hex_digit_t d [8];
        for (int i = 0; i < 8; i++)
            read_digit(i, d[i]);
        check_sample("digits 5 to 0", {d[5], d[4], d[3], d[2], d[1], d[0]}, exp_sample);
        if (d[7] > 4'h1) begin
            $display("Digit 7 shows %h, but a peak level never exceeds 1 there", d[7]);
            abort_run();
        end
        check_level("digits 7 and 6", {d[7][0], d[6]}, exp_peak);
    endtask

    // --------------------
    // Stimulus
    // --------------------

    initial begin
        arst_n      = 1'b0;
        btnc        = 1'b0;
        btnu        = 1'b0;
        btnl        = 1'b0;
        btnr        = 1'b0;
        btnd        = 1'b0;
        sw          = '0;
        left        = '0;
        right       = '0;
        lcg_state   = 32'd99765;
        model_shown = '0;
        model_peak  = '0;
        model_level = '0;
        next_tick   = slow_period / 2;
        build_table();

        repeat (2) @(posedge clk);
        #2;
        arst_n = 1'b1;

        // Nothing captured yet, the microphone sends silence.
        @(negedge clk);
        check_pin("jd_sck", jd_sck, 1'b0);
        check_pin("jd_ws", jd_ws, 1'b0);
        check_pin("jd_lr", jd_lr, 1'b0);
        check_pin("jd_gnd", jd_gnd, 1'b0);
        check_pin("jd_vcc", jd_vcc, 1'b1);
        check_led("led", led, 16'h0000);
        check_display('0, '0);

        for (int k = 0; k < rows.size(); k++) begin
            cur = rows[k];

            // Keep rows clear of slow ticks, a tick here clears to the settled level.
            if (next_tick - cycle_cnt < tick_margin) begin
                while (cycle_cnt < next_tick + 16)
                    @(posedge clk);
                model_peak = model_level;
                next_tick  = next_tick + slow_period;
            end

            @(posedge clk);
            #2;
            left  = cur.left;
            right = cur.right;
            sw    = {15'b0, cur.sw0};
            cur   = predict(cur);

            repeat (3) wait_ws_fall();

            if (cur.btnc) begin
                @(posedge clk);
                #2 btnc = 1'b1;
                @(posedge clk);
                #2 btnc = 1'b0;
            end

            if (cur.hold) begin
                repeat (hold_clks) @(posedge clk);
                next_tick = next_tick + slow_period;
            end

            @(negedge clk);
            check_led("led", led, cur.exp_led);
            check_display(cur.exp_sample, cur.exp_peak);

            if (cycle_cnt + 4 > next_tick) begin
                $display("A slow tick fell inside row %0d", k);
                abort_run();
            end
        end

        $display("Done: no errors");
        $finish;
    end

endmodule

`default_nettype wire

/* project.f */
hw/audio_pkg.sv
hw/board_pkg.sv
hw/slow_clk_gen.sv
hw/inmp441_mic_i2s_receiver.sv
hw/seven_segment_display.sv
hw/lab_top.sv
hw/board_specific_top.sv
verification/inmp441_mic_model.sv
verification/tb_board_specific_top.sv

/* Makefile */
LOG := sim.log

.PHONY: sim clean

sim:
	verilator --binary --timing -Wno-fatal -f project.f \
		--top-module tb_board_specific_top -Mdir obj_dir
	./obj_dir/Vtb_board_specific_top | tee $(LOG)
	grep -q "Done: no errors" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
